/* hw/fpu_in_defines.svh */
////////////////////
// sizing for the fpu input controller
// queue depth must stay a power of two with one wrap bit in the pointer
////////////////////
`ifndef FPU_IN_DEFINES_SVH
`define FPU_IN_DEFINES_SVH

////////////////////
// tag queues
////////////////////

`define FPU_INQ_DEPTH 8         // tags held per queue
`define FPU_INQ_PTR_W 4         // index bits plus the wrap bit

////////////////////
// pipe tag and bus
////////////////////

// one-hot pipe select {div, mul, add}
`define FPU_TAG_W 3

`define FPU_APB_AW 4            // byte offsets of the register block

`endif

/* hw/fpu_req_pkg.sv */
////////////////////
// request header encoding as seen on the incoming request port
// only the fpop groups are decoded and every other type is dropped
////////////////////
`default_nettype none

package fpu_req_pkg;

        // the 5-bit type field is compared whole for the group
        // and split for the class check
        typedef union packed {
                logic [4:0] code;               // packet type code
                struct packed {
                        logic [3:0] cls;        // operation class
                        logic       grp;        // 0 first opcode group, 1 second
                } fields;
        } fp_type_u;

        ////////////////////
        // type codes
        ////////////////////

        localparam logic [4:0] FP_TYPE_FPOP1 = 5'h0a;   // add group, op7 set
        localparam logic [4:0] FP_TYPE_FPOP2 = 5'h0b;   // add, mul, div group, op7 clear

        localparam logic [3:0] FP_CLASS_FPOP = 4'h5;    // shared by both groups

        ////////////////////
        // opcode bits 3:2
        ////////////////////

        localparam logic [1:0] FP_OP_MUL = 2'b10;
        localparam logic [1:0] FP_OP_DIV = 2'b11;

endpackage

`default_nettype wire

/* hw/fpu_in_reg_pkg.sv */
////////////////////
// APB register map of the input controller
// unmapped offsets read as zero and ignore writes
////////////////////
`default_nettype none

`include "fpu_in_defines.svh"

package fpu_in_reg_pkg;

        // offsets
        localparam logic [`FPU_APB_AW-1:0] REG_CTRL_ADDR   = 4'h0;
        localparam logic [`FPU_APB_AW-1:0] REG_STATUS_ADDR = 4'h4;

        ////////////////////
        // control register
        ////////////////////

        localparam int unsigned CTRL_PM_EN_BIT  = 0;    // pipe clock gating on
        localparam int unsigned CTRL_FWD_EN_BIT = 1;    // forward past empty queue

        localparam logic [31:0] CTRL_RESET = 32'h0000_0003;

        // status register is read only
        localparam int unsigned STATUS_MAIN_EMPTY_BIT = 0;
        localparam int unsigned STATUS_DIV_EMPTY_BIT  = 1;

endpackage

`default_nettype wire

/* hw/fpu_in_decode.sv */
////////////////////
// tag appears in the cycle after the request is presented
// no back-pressure toward the sender
////////////////////
`default_nettype none

`include "fpu_in_defines.svh"

module fpu_in_decode (
        input  wire logic                  rclk,
        input  wire logic                  i_arst_n,
        input  wire logic                  i_req_rdy,
        input  wire logic                  i_req_vld,
        input  wire fpu_req_pkg::fp_type_u i_req_type,
        input  wire logic [3:2]            i_req_op,
        input  wire logic                  i_req_op7,
        output logic [`FPU_TAG_W-1:0]      o_tag,
        output logic                       o_is_div
);
        import fpu_req_pkg::*;

        logic       rdy_q;
        logic       vld_q;
        fp_type_u   type_q;
        logic [3:2] op_q;
        logic       op7_q;

        logic       pkt_ok;
        logic       grp1_hit;
        logic       grp2_hit;
        logic       add_hit;
        logic       mul_hit;
        logic       div_hit;

        ////////////////////
        // capture
        ////////////////////

        always_ff @(posedge rclk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        rdy_q <= 1'b0;          // qualifies everything below
                end else begin
                        rdy_q <= i_req_rdy;
                end
        end

        always_ff @(posedge rclk) begin
                vld_q  <= i_req_vld;
                type_q <= i_req_type;
                op_q   <= i_req_op;
                op7_q  <= i_req_op7;
        end

        ////////////////////
        // decode
        ////////////////////

        assign pkt_ok   = rdy_q & vld_q & (type_q.fields.cls == FP_CLASS_FPOP);
        assign grp1_hit = pkt_ok & (type_q.code == FP_TYPE_FPOP1) & op7_q;
        assign grp2_hit = pkt_ok & (type_q.code == FP_TYPE_FPOP2) & ~op7_q;

        assign add_hit = grp1_hit | (grp2_hit & ~op_q[3]);
        assign mul_hit = grp2_hit & (op_q == FP_OP_MUL);
        assign div_hit = grp2_hit & (op_q == FP_OP_DIV);

        assign o_tag    = {div_hit, mul_hit, add_hit};
        assign o_is_div = div_hit;     // routes the tag to the divide queue

endmodule

`default_nettype wire

/* hw/fpu_in_tagq.sv */
////////////////////
// sender must never write a full queue
// head tag is combinational and includes the forward path
////////////////////
`default_nettype none

`include "fpu_in_defines.svh"

module fpu_in_tagq (
        input  wire logic                  rclk,
        input  wire logic                  i_arst_n,
        input  wire logic                  i_wr,
        input  wire logic [`FPU_TAG_W-1:0] i_wr_tag,
        input  wire logic [`FPU_TAG_W-1:0] i_step,
        input  wire logic                  i_fwd_en,
        output logic [`FPU_TAG_W-1:0]      o_head_tag,
        output logic                       o_empty
);
        localparam int IDX_W = `FPU_INQ_PTR_W - 1;

        logic [`FPU_TAG_W-1:0]     mem [`FPU_INQ_DEPTH];
        logic [`FPU_INQ_PTR_W-1:0] wr_ptr;
        logic [`FPU_INQ_PTR_W-1:0] rd_ptr;
        logic [`FPU_TAG_W-1:0]     fwd_tag;
        logic                      pop;

        ////////////////////
        // head and pop
        ////////////////////

        assign o_empty = (wr_ptr == rd_ptr);   // wrap bits equal as well

        // incoming tag is shown only when nothing older is waiting
        assign fwd_tag    = (i_fwd_en && i_wr) ? i_wr_tag : '0;
        assign o_head_tag = o_empty ? fwd_tag : mem[rd_ptr[IDX_W-1:0]];

        assign pop = |(o_head_tag & i_step);    // matching pipe took the head

        ////////////////////
        // storage
        ////////////////////

        always_ff @(posedge rclk) begin
                if (i_wr) begin
                        mem[wr_ptr[IDX_W-1:0]] <= i_wr_tag;
                end
        end

        // a forwarded tag stepped this cycle moves both pointers
        // and leaves the queue empty
        always_ff @(posedge rclk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        if (i_wr) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (pop) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                end
        end

endmodule

`default_nettype wire

/* hw/fpu_in_clkgate.sv */
////////////////////
// enables are active low and stay active until the first edge after reset
////////////////////
`default_nettype none

`include "fpu_in_defines.svh"

module fpu_in_clkgate (
        input  wire logic                  rclk,
        input  wire logic                  i_arst_n,
        input  wire logic [`FPU_TAG_W-1:0] i_req,
        input  wire logic [`FPU_TAG_W-1:0] i_pipe_active,
        input  wire logic                  i_pm_en,
        output logic [`FPU_TAG_W-1:0]      o_clken_l
);
        logic [`FPU_TAG_W-1:0] req_q;          // request one cycle back
        logic                  rst_hold_q;
        logic                  force_on;

        always_ff @(posedge rclk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        req_q      <= '0;
                        rst_hold_q <= 1'b1;
                end else begin
                        req_q      <= i_req;
                        rst_hold_q <= 1'b0;
                end
        end

        assign force_on = ~i_pm_en | rst_hold_q;       // gating off or leaving reset

        // per pipe: busy, requested now, or requested last cycle
        assign o_clken_l = ~(i_pipe_active | i_req | req_q | {`FPU_TAG_W{force_on}});

endmodule

`default_nettype wire

/* hw/fpu_in_regs.sv */
////////////////////
// APB slave with no wait states and no error response
// read data is driven combinationally while psel is high
////////////////////
`default_nettype none

`include "fpu_in_defines.svh"

module fpu_in_regs (
        input  wire logic                   rclk,
        input  wire logic                   i_arst_n,
        input  wire logic                   i_psel,
        input  wire logic                   i_penable,
        input  wire logic                   i_pwrite,
        input  wire logic [`FPU_APB_AW-1:0] i_paddr,
        input  wire logic [31:0]            i_pwdata,
        input  wire logic                   i_main_empty,
        input  wire logic                   i_div_empty,
        output logic [31:0]                 o_prdata,
        output logic                        o_pm_en,
        output logic                        o_fwd_en
);
        import fpu_in_reg_pkg::*;

        logic pm_en_q;
        logic fwd_en_q;
        logic ctrl_wr;
        logic rd_sel;

        ////////////////////
        // access decode
        ////////////////////

        // writes land at the edge ending the access phase
        assign ctrl_wr = i_psel & i_penable & i_pwrite & (i_paddr == REG_CTRL_ADDR);
        assign rd_sel  = i_psel & ~i_pwrite;

        always_ff @(posedge rclk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        pm_en_q  <= CTRL_RESET[CTRL_PM_EN_BIT];
                        fwd_en_q <= CTRL_RESET[CTRL_FWD_EN_BIT];
                end else if (ctrl_wr) begin
                        pm_en_q  <= i_pwdata[CTRL_PM_EN_BIT];
                        fwd_en_q <= i_pwdata[CTRL_FWD_EN_BIT];
                end
        end

        ////////////////////
        // read back
        ////////////////////

        always_comb begin
                o_prdata = '0;
                if (rd_sel) begin
                        case (i_paddr)
                        REG_CTRL_ADDR: begin
                                o_prdata[CTRL_PM_EN_BIT]  = pm_en_q;
                                o_prdata[CTRL_FWD_EN_BIT] = fwd_en_q;
                        end
                        REG_STATUS_ADDR: begin
                                // live flags, not sampled
                                o_prdata[STATUS_MAIN_EMPTY_BIT] = i_main_empty;
                                o_prdata[STATUS_DIV_EMPTY_BIT]  = i_div_empty;
                        end
                        default: begin
                                o_prdata = '0;
                        end
                        endcase
                end
        end

        assign o_pm_en  = pm_en_q;
        assign o_fwd_en = fwd_en_q;

endmodule

`default_nettype wire

/* hw/fpu_in_top.sv */
////////////////////
// request outputs stay high until the matching pipe steps
// add and mul share one queue and divide has its own
////////////////////
`default_nettype none

`include "fpu_in_defines.svh"

module fpu_in_top (
        input  wire logic                   rclk,
        input  wire logic                   i_arst_n,
        input  wire logic                   i_req_rdy,
        input  wire logic                   i_req_vld,
        input  wire fpu_req_pkg::fp_type_u  i_req_type,
        input  wire logic [3:2]             i_req_op,
        input  wire logic                   i_req_op7,
        input  wire logic                   i_a1stg_step,       // add pipe load
        input  wire logic                   i_m1stg_step,       // mul pipe load
        input  wire logic                   i_d1stg_step,       // div pipe load
        input  wire logic                   i_add_pipe_active,
        input  wire logic                   i_mul_pipe_active,
        input  wire logic                   i_div_pipe_active,
        input  wire logic                   i_psel,
        input  wire logic                   i_penable,
        input  wire logic                   i_pwrite,
        input  wire logic [`FPU_APB_AW-1:0] i_paddr,
        input  wire logic [31:0]            i_pwdata,
        output logic [31:0]                 o_prdata,
        output logic                        o_inq_add,
        output logic                        o_inq_mul,
        output logic                        o_inq_div,
        output logic                        o_fadd_clken_l,
        output logic                        o_fmul_clken_l,
        output logic                        o_fdiv_clken_l
);
        logic [`FPU_TAG_W-1:0] dec_tag;
        logic                  dec_is_div;
        logic                  main_wr;
        logic                  div_wr;
        logic [`FPU_TAG_W-1:0] step_vec;
        logic [`FPU_TAG_W-1:0] main_head;
        logic [`FPU_TAG_W-1:0] div_head;
        logic                  main_empty;
        logic                  div_empty;
        logic [`FPU_TAG_W-1:0] inq_req;
        logic [`FPU_TAG_W-1:0] active_vec;
        logic [`FPU_TAG_W-1:0] clken_l;
        logic                  pm_en;
        logic                  fwd_en;

        fpu_in_decode u_decode (
                .rclk       (rclk),
                .i_arst_n   (i_arst_n),
                .i_req_rdy  (i_req_rdy),
                .i_req_vld  (i_req_vld),
                .i_req_type (i_req_type),
                .i_req_op   (i_req_op),
                .i_req_op7  (i_req_op7),
                .o_tag      (dec_tag),
                .o_is_div   (dec_is_div)
        );

        ////////////////////
        // tag queues
        ////////////////////

        assign main_wr  = (|dec_tag) & ~dec_is_div;
        assign div_wr   = dec_is_div;
        assign step_vec = {i_d1stg_step, i_m1stg_step, i_a1stg_step};

        fpu_in_tagq u_main_q (
                .rclk       (rclk),
                .i_arst_n   (i_arst_n),
                .i_wr       (main_wr),
                .i_wr_tag   (dec_tag),
                .i_step     (step_vec),
                .i_fwd_en   (fwd_en),
                .o_head_tag (main_head),
                .o_empty    (main_empty)
        );

        fpu_in_tagq u_div_q (
                .rclk       (rclk),
                .i_arst_n   (i_arst_n),
                .i_wr       (div_wr),
                .i_wr_tag   (dec_tag),
                .i_step     (step_vec),
                .i_fwd_en   (fwd_en),
                .o_head_tag (div_head),
                .o_empty    (div_empty)
        );

        // heads never overlap since each queue holds its own pipes
        assign inq_req   = main_head | div_head;
        assign o_inq_add = inq_req[0];
        assign o_inq_mul = inq_req[1];
        assign o_inq_div = inq_req[2];

        ////////////////////
        // clocks and registers
        ////////////////////

        assign active_vec = {i_div_pipe_active, i_mul_pipe_active, i_add_pipe_active};

        fpu_in_clkgate u_clkgate (
                .rclk          (rclk),
                .i_arst_n      (i_arst_n),
                .i_req         (inq_req),
                .i_pipe_active (active_vec),
                .i_pm_en       (pm_en),
                .o_clken_l     (clken_l)
        );

        assign o_fadd_clken_l = clken_l[0];
        assign o_fmul_clken_l = clken_l[1];
        assign o_fdiv_clken_l = clken_l[2];

        fpu_in_regs u_regs (
                .rclk         (rclk),
                .i_arst_n     (i_arst_n),
                .i_psel       (i_psel),
                .i_penable    (i_penable),
                .i_pwrite     (i_pwrite),
                .i_paddr      (i_paddr),
                .i_pwdata     (i_pwdata),
                .i_main_empty (main_empty),
                .i_div_empty  (div_empty),
                .o_prdata     (o_prdata),
                .o_pm_en      (pm_en),
                .o_fwd_en     (fwd_en)
        );

endmodule

`default_nettype wire

/* dv/fpu_in_chk.sv */
////////////////////
// bound into every tag queue and reads its pointers directly
////////////////////
`default_nettype none

`include "fpu_in_defines.svh"

module fpu_in_chk (
        input wire logic                      i_rclk,
        input wire logic                      i_arst_n,
        input wire logic                      i_wr,
        input wire logic [`FPU_TAG_W-1:0]     i_head_tag,
        input wire logic [`FPU_INQ_PTR_W-1:0] i_wr_ptr,
        input wire logic [`FPU_INQ_PTR_W-1:0] i_rd_ptr
);
        localparam int IDX_W = `FPU_INQ_PTR_W - 1;
        localparam logic [`FPU_INQ_PTR_W-1:0] DEPTH = `FPU_INQ_DEPTH;

        int unsigned               n_fail = 0;  // read by the testbench at the end
        logic                      full;
        logic [`FPU_INQ_PTR_W-1:0] occ;

        // same index, opposite wrap bit
        assign full = (i_wr_ptr[IDX_W] != i_rd_ptr[IDX_W]) &&
                      (i_wr_ptr[IDX_W-1:0] == i_rd_ptr[IDX_W-1:0]);

        assign occ = i_wr_ptr - i_rd_ptr;      // entries held, wraps high on underflow

        head_onehot: assert property (@(posedge i_rclk) disable iff (!i_arst_n)
                $onehot0(i_head_tag))
                else begin
                        n_fail++;
                        $error("head tag %b is not zero or one-hot", i_head_tag);
                end

        no_wr_full: assert property (@(posedge i_rclk) disable iff (!i_arst_n)
                !(i_wr && full))
                else begin
                        n_fail++;
                        $error("tag written into a full queue");
                end

        occ_range: assert property (@(posedge i_rclk) disable iff (!i_arst_n)
                occ <= DEPTH)
                else begin
                        n_fail++;
                        $error("queue holds %0d entries, pointers out of range", occ);
                end

endmodule

bind fpu_in_tagq fpu_in_chk u_chk (
        .i_rclk     (rclk),
        .i_arst_n   (i_arst_n),
        .i_wr       (i_wr),
        .i_head_tag (o_head_tag),
        .i_wr_ptr   (wr_ptr),
        .i_rd_ptr   (rd_ptr)
);

`default_nettype wire

/* dv/fpu_in_tb.sv */
////////////////////
// replays dv/fpu_in_golden.txt from the project root, one line per clock
// STATUS is read back to back during replay and checked in the access phase
////////////////////
`default_nettype none

`include "fpu_in_defines.svh"

module fpu_in_tb;
        import fpu_req_pkg::*;
        import fpu_in_reg_pkg::*;

        localparam int CLK_PERIOD = 8;

        logic                   rclk = 1'b0;
        logic                   arst_n;
        logic                   req_rdy;
        logic                   req_vld;
        fp_type_u               req_type;
        logic [3:2]             req_op;
        logic                   req_op7;
        logic [`FPU_TAG_W-1:0]  step;           // {div, mul, add}
        logic [`FPU_TAG_W-1:0]  active;
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`FPU_APB_AW-1:0] paddr;
        logic [31:0]            pwdata;
        logic [31:0]            prdata;
        logic                   inq_add;
        logic                   inq_mul;
        logic                   inq_div;
        logic                   fadd_clken_l;
        logic                   fmul_clken_l;
        logic                   fdiv_clken_l;

        string       golden[$];
        int          n_lines = 0;
        bit          loaded = 1'b0;
        int          cur_test = 0;
        int          n_tests = 0;
        int          n_checks = 0;
        int          n_errors = 0;
        int          test_checks = 0;
        int          test_errors = 0;
        logic [31:0] cur_ctrl = 32'h0000_0003;  // both features on out of reset

        always #(CLK_PERIOD / 2) rclk = ~rclk;

        fpu_in_top UUT (
                .rclk (rclk), .i_arst_n (arst_n),
                .i_req_rdy (req_rdy), .i_req_vld (req_vld), .i_req_type (req_type),
                .i_req_op (req_op), .i_req_op7 (req_op7),
                .i_a1stg_step (step[0]), .i_m1stg_step (step[1]), .i_d1stg_step (step[2]),
                .i_add_pipe_active (active[0]), .i_mul_pipe_active (active[1]),
                .i_div_pipe_active (active[2]),
                .i_psel (psel), .i_penable (penable), .i_pwrite (pwrite),
                .i_paddr (paddr), .i_pwdata (pwdata), .o_prdata (prdata),
                .o_inq_add (inq_add), .o_inq_mul (inq_mul), .o_inq_div (inq_div),
                .o_fadd_clken_l (fadd_clken_l), .o_fmul_clken_l (fmul_clken_l),
                .o_fdiv_clken_l (fdiv_clken_l)
        );

        ////////////////////
        // compare and report
        ////////////////////

        task automatic check_tag(input string name, input logic [`FPU_TAG_W-1:0] got,
                                 input logic [`FPU_TAG_W-1:0] exp);
                test_checks++;
                if (got !== exp) begin
                        test_errors++;
                        $display("[ERROR] t=%0t %s exp=%b got=%b", $time, name, exp, got);
                end
        endtask

        task automatic check_clken(input string name, input logic [`FPU_TAG_W-1:0] got,
                                   input logic [`FPU_TAG_W-1:0] exp);
                test_checks++;
                if (got !== exp) begin
                        test_errors++;
                        $display("[ERROR] t=%0t %s exp=%b got=%b", $time, name, exp, got);
                end
        endtask

        task automatic check_reg(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
                test_checks++;
                if (got !== exp) begin
                        test_errors++;
                        $display("[ERROR] t=%0t %s exp=%h got=%h", $time, name, exp, got);
                end
        endtask

        function automatic string test_name(input int id);
                case (id)
                1:       return "reset_defaults";
                2:       return "decode_forward";
                3:       return "queue_order";
                4:       return "forward_off";
                5:       return "clock_gating";
                default: return "unknown";
                endcase
        endfunction

        task automatic finish_test();
                $display("test %0d %s: %0d checks, %0d errors", cur_test,
                         test_name(cur_test), test_checks, test_errors);
                n_tests++;
                n_checks += test_checks;
                n_errors += test_errors;
                test_checks = 0;
                test_errors = 0;
        endtask

        ////////////////////
        // bus and stimulus
        ////////////////////

        task automatic drive_idle();
                req_rdy       <= 1'b0;
                req_vld       <= 1'b0;
                req_type.code <= '0;
                req_op        <= '0;
                req_op7       <= 1'b0;
                step          <= '0;
                active        <= '0;
        endtask

        // write lands at the caller's next rising edge
        task automatic apb_write(input logic [`FPU_APB_AW-1:0] addr, input logic [31:0] data);
                @(posedge rclk);
                psel    <= 1'b1;
                penable <= 1'b0;
                pwrite  <= 1'b1;
                paddr   <= addr;
                pwdata  <= data;
                drive_idle();
                @(posedge rclk);
                penable <= 1'b1;
        endtask

        task automatic apb_read(input logic [`FPU_APB_AW-1:0] addr, output logic [31:0] data);
                @(posedge rclk);
                psel    <= 1'b1;
                penable <= 1'b0;
                pwrite  <= 1'b0;
                paddr   <= addr;
                @(posedge rclk);
                penable <= 1'b1;
                @(negedge rclk);
                data = prdata;          // access phase
        endtask

        task automatic load_golden();
                int    fd;
                int    rc;
                string line;
                fd = $fopen("dv/fpu_in_golden.txt", "r");
                if (fd != 0) begin
                        while (!$feof(fd)) begin
                                rc = $fgets(line, fd);
                                if (rc > 1 && line.getc(0) != 8'h23) begin     // '#' lines
                                        golden.push_back(line);
                                end
                        end
                        $fclose(fd);
                end
                n_lines = golden.size();
                loaded  = 1'b1;
        endtask

        ////////////////////
        // tests
        ////////////////////

        task automatic run_reset_test();
                logic [31:0] rd;
                cur_test = 1;
                repeat (7) @(posedge rclk);
                @(negedge rclk);
                check_clken("o_clken_l in reset", {fdiv_clken_l, fmul_clken_l, fadd_clken_l}, '0);
                @(posedge rclk);
                arst_n <= 1'b1;
                repeat (2) @(posedge rclk);
                @(negedge rclk);
                check_tag("o_inq", {inq_div, inq_mul, inq_add}, '0);
                check_clken("o_clken_l", {fdiv_clken_l, fmul_clken_l, fadd_clken_l}, '1);
                apb_read(REG_CTRL_ADDR, rd);
                check_reg("ctrl", rd, 32'h0000_0003);
                apb_read(REG_STATUS_ADDR, rd);
                check_reg("status", rd, 32'h0000_0003);        // both queues empty
                apb_read(4'h8, rd);
                check_reg("unmapped", rd, '0);
                finish_test();
        endtask

        task automatic run_replay();
                int         rc;
                int         id;
                logic [4:0] typ;
                logic [3:0] rdy, vld, op, op7, stp, act, ctl, e_req, e_clk, e_st;
                bit         access;
                access = 1'b0;
                foreach (golden[i]) begin
                        rc = $sscanf(golden[i], "%d %h %h %h %h %h %h %h %h %h %h %h",
                                     id, rdy, vld, typ, op, op7, stp, act, ctl,
                                     e_req, e_clk, e_st);
                        if (rc != 12) begin
                                $display("golden line %0d could not be parsed", i + 1);
                                test_errors++;
                        end else begin
                                if (id != cur_test) begin
                                        if (i > 0) finish_test();
                                        cur_test = id;
                                end
                                if ({28'h0, ctl} != cur_ctrl) begin
                                        apb_write(REG_CTRL_ADDR, {28'h0, ctl});
                                        cur_ctrl = {28'h0, ctl};
                                        access   = 1'b0;
                                end
                                @(posedge rclk);
                                req_rdy       <= rdy[0];
                                req_vld       <= vld[0];
                                req_type.code <= typ;
                                req_op        <= op[1:0];
                                req_op7       <= op7[0];
                                step          <= stp[2:0];
                                active        <= act[2:0];
                                psel          <= 1'b1;          // STATUS reads run alongside
                                pwrite        <= 1'b0;
                                paddr         <= REG_STATUS_ADDR;
                                penable       <= access;
                                @(negedge rclk);
                                check_tag("o_inq", {inq_div, inq_mul, inq_add}, e_req[2:0]);
                                check_clken("o_clken_l",
                                            {fdiv_clken_l, fmul_clken_l, fadd_clken_l}, e_clk[2:0]);
                                if (access) check_reg("status", prdata, {28'h0, e_st});
                                access = ~access;
                        end
                end
                finish_test();
        endtask

        initial begin : watchdog
                wait (loaded);
                #((n_lines + 200) * CLK_PERIOD);
                $display("watchdog expired after %0d cycles, run did not finish", n_lines + 200);
                $display("Simulation failed");
                $finish;
        end

        initial begin : main
                int n_assert;
                arst_n        = 1'b0;
                req_rdy       = 1'b0;
                req_vld       = 1'b0;
                req_type.code = '0;
                req_op        = '0;
                req_op7       = 1'b0;
                step          = '0;
                active        = '0;
                psel          = 1'b0;
                penable       = 1'b0;
                pwrite        = 1'b0;
                paddr         = '0;
                pwdata        = '0;
                load_golden();
                if (n_lines == 0) begin
                        $display("golden file dv/fpu_in_golden.txt is missing or holds no data");
                        n_errors++;
                end else begin
                        run_reset_test();
                        run_replay();
                end
                n_assert = UUT.u_main_q.u_chk.n_fail + UUT.u_div_q.u_chk.n_fail;
                if (n_assert != 0) begin
                        $display("tag queue assertions failed %0d times", n_assert);
                        n_errors += n_assert;
                end
                $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
                if (n_errors == 0) begin
                        $display("Simulation completed successfully");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* dv/fpu_in_golden.txt */
# test rdy vld type op op7 step active ctrl exp_req exp_clken_l exp_status (all hex)
# step, active, exp_req and exp_clken_l are {div,mul,add}; exp_status is {div_empty,main_empty}
2 1 1 0a 0 1 0 0 3 0 7 3
2 0 0 00 0 0 1 0 3 1 6 3
2 1 1 0b 2 0 0 0 3 0 6 3
2 0 0 00 0 0 2 0 3 2 5 3
2 1 1 0b 3 0 0 0 3 0 5 3
2 0 0 00 0 0 4 0 3 4 3 3
2 0 0 00 0 0 0 0 3 0 3 3
3 1 1 0b 0 0 0 0 3 0 7 3
3 1 1 0b 2 0 0 0 3 1 6 3
3 1 1 0a 0 1 0 0 3 1 6 2
3 1 1 0b 2 0 0 0 3 1 6 2
3 1 0 0b 3 0 0 0 3 1 6 2
3 1 1 04 3 0 0 0 3 1 6 2
3 1 1 0b 3 0 0 0 3 1 6 2
3 0 0 00 0 0 1 0 3 5 2 2
3 0 0 00 0 0 4 0 3 6 0 0
3 0 0 00 0 0 2 0 3 2 1 2
3 0 0 00 0 0 2 0 3 1 4 2
3 0 0 00 0 0 1 0 3 1 6 2
3 0 0 00 0 0 2 0 3 2 4 2
3 0 0 00 0 0 0 0 3 0 5 3
4 1 1 0a 0 1 0 0 1 0 7 3
4 0 0 00 0 0 0 0 1 0 7 3
4 0 0 00 0 0 0 0 1 1 6 2
4 0 0 00 0 0 1 0 1 1 6 2
4 0 0 00 0 0 0 0 1 0 6 3
5 0 0 00 0 0 0 1 3 0 6 3
5 1 1 0b 2 0 0 2 3 0 5 3
5 0 0 00 0 0 0 0 3 2 5 3
5 0 0 00 0 0 2 0 3 2 5 2
5 0 0 00 0 0 0 0 3 0 5 3
5 0 0 00 0 0 0 0 3 0 7 3
5 0 0 00 0 0 0 0 0 0 0 3
5 1 1 0a 0 1 0 0 0 0 0 3
5 0 0 00 0 0 0 0 0 0 0 3
5 0 0 00 0 0 1 0 0 1 0 2
5 0 0 00 0 0 0 0 0 0 0 3

/* project.f */
+incdir+hw
hw/fpu_req_pkg.sv
hw/fpu_in_reg_pkg.sv
hw/fpu_in_decode.sv
hw/fpu_in_tagq.sv
hw/fpu_in_clkgate.sv
hw/fpu_in_regs.sv
hw/fpu_in_top.sv
dv/fpu_in_chk.sv
dv/fpu_in_tb.sv

/* Makefile */
# Verilator build and run of the FPU input controller testbench

BIN  := obj_dir/Vfpu_in_tb
SRCS := $(filter-out +incdir+%,$(shell cat project.f)) hw/fpu_in_defines.svh

.PHONY: all run clean

all: run

$(BIN): project.f $(SRCS)
	verilator --binary --assert --top-module fpu_in_tb -f project.f

run: $(BIN) dv/fpu_in_golden.txt
	./$(BIN) | tee sim.log
	grep -q "^Simulation completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log
